// ==== design/sub_defines.svh ====
`ifndef SUB_DEFINES_SVH
`define SUB_DEFINES_SVH

// operand and result word width
`define SUB_WIDTH 16

// prefix tree: 0 serial, 1 brent-kung, 2 sklansky
`define SUB_SPEED 2

`define SUB_QDEPTH 4       // result slots, also upstream credits at start
`define SUB_OUT_CREDITS 2  // downstream credits held out of reset

`endif

// ==== design/subPkg.sv ====
`include "sub_defines.svh"

package subPkg;

	// signed operand or result word, two's complement
	typedef logic [`SUB_WIDTH-1:0] operand_t;

	// downstream credit counter, holds 0 up to the reset value
	typedef logic [$clog2(`SUB_OUT_CREDITS+1)-1:0] credit_t;

	// index into the result queue
	typedef logic [$clog2(`SUB_QDEPTH)-1:0] qPtr_t;

endpackage

// ==== design/PrefixAndOr.sv ====
module PrefixAndOr #(
	parameter int width = 8, // bits in the prefix
	parameter int speed = 0  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] GI, // generate in
	input  logic [width-1:0] PI, // propagate in
	output logic [width-1:0] GO, // group generate out
	output logic [width-1:0] PO  // group propagate out
);

	localparam int m = $clog2(width); // tree depth

	if (speed == 2) begin : fastPrefix
		// sklansky, log depth, fanout doubles per level
		logic [width-1:0] gLvl [0:m];
		logic [width-1:0] pLvl [0:m];

		assign gLvl[0] = GI;
		assign pLvl[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : levels
			for (genvar j = 0; j < width; j++) begin : bits
				if (((j >> (l - 1)) % 2) == 1) begin : black // upper half of block
					localparam int src = j - (j % (2 ** (l - 1))) - 1; // top of lower half
					assign gLvl[l][j] = gLvl[l-1][j] | (pLvl[l-1][j] & gLvl[l-1][src]);
					assign pLvl[l][j] = pLvl[l-1][j] & pLvl[l-1][src];
				end else begin : white
					assign gLvl[l][j] = gLvl[l-1][j];
					assign pLvl[l][j] = pLvl[l-1][j];
				end
			end
		end
		assign GO = gLvl[m];
		assign PO = pLvl[m];
	end else if (speed == 1) begin : mediumPrefix
		// brent-kung: m up-sweep levels, then m-1 down-sweep levels
		localparam int lvls = 2 * m - 1;
		logic [width-1:0] gLvl [0:lvls];
		logic [width-1:0] pLvl [0:lvls];

		assign gLvl[0] = GI;
		assign pLvl[0] = PI;
		for (genvar l = 1; l <= lvls; l++) begin : levels
			// span halves on the way down
			localparam int span = (l <= m) ? 2 ** (l - 1) : 2 ** (2 * m - 1 - l);
			for (genvar j = 0; j < width; j++) begin : bits
				localparam bit upNode = (l <= m) && (((j + 1) % (2 * span)) == 0);
				localparam bit downNode = (l > m) && (((j + 1) % (2 * span)) == span)
					&& (j >= 2 * span);
				if (upNode || downNode) begin : black
					assign gLvl[l][j] = gLvl[l-1][j] | (pLvl[l-1][j] & gLvl[l-1][j-span]);
					assign pLvl[l][j] = pLvl[l-1][j] & pLvl[l-1][j-span];
				end else begin : white
					assign gLvl[l][j] = gLvl[l-1][j];
					assign pLvl[l][j] = pLvl[l-1][j];
				end
			end
		end
		assign GO = gLvl[lvls];
		assign PO = pLvl[lvls];
	end else begin : slowPrefix
		// ripple chain, width-1 levels deep
		logic [width-1:0] gChain;
		logic [width-1:0] pChain;

		assign gChain[0] = GI[0];
		assign pChain[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : bits
			assign gChain[i] = GI[i] | (PI[i] & gChain[i-1]);
			assign pChain[i] = PI[i] & pChain[i-1];
		end
		assign GO = gChain;
		assign PO = pChain;
	end

endmodule

// ==== design/SubV.sv ====
module SubV #(
	parameter int width = 8, // word width
	parameter int speed = 0  // prefix structure select
) (
	input  logic [width-1:0] A,  // minuend
	input  logic [width-1:0] B,  // subtrahend
	input  logic             CI, // borrow in
	output logic [width-1:0] S,  // A - B - CI, wrapped
	output logic             V   // two's complement overflow
);

	logic [width-1:0] bInv;    // ones complement of B
	logic             cInv;    // borrow turned into carry
	logic [width-1:0] gIn;
	logic [width-1:0] pIn;
	logic [width-1:0] gOut;    // carry out of each bit
	logic [width-1:0] halfSum; // bitwise A xor ~B

	assign bInv = ~B;
	assign cInv = ~CI;

	// carry in folded into bit 0, so gOut[i] is the true carry out of bit i
	assign gIn[0] = (A[0] & bInv[0]) | (cInv & (A[0] | bInv[0]));
	assign pIn[0] = 1'b0;
	assign halfSum[0] = A[0] ^ bInv[0];

	for (genvar i = 1; i < width; i++) begin : preBits
		assign gIn[i] = A[i] & bInv[i];
		assign pIn[i] = A[i] | bInv[i];
		assign halfSum[i] = A[i] ^ bInv[i];
	end

	PrefixAndOr #(.width(width), .speed(speed)) prefix (
		.GI(gIn), .PI(pIn), .GO(gOut), .PO()
	);

	assign S = halfSum ^ {gOut[width-2:0], cInv};
	assign V = gOut[width-1] ^ gOut[width-2]; // carry into msb differs from carry out

endmodule

// ==== design/diffStage.sv ====
`include "sub_defines.svh"

module diffStage (
	input  logic             clk,
	input  logic             rst,
	input  logic             inValid,
	input  subPkg::operand_t inA,
	input  subPkg::operand_t inB,
	input  logic             inBorrow,
	input  logic             inSat,
	output logic             entryValid,    // one cycle after inValid
	output subPkg::operand_t entryResult,
	output logic             entryOverflow  // raw flag, kept when clamped
);

	// clamp targets
	localparam subPkg::operand_t maxPos = {1'b0, {(`SUB_WIDTH-1){1'b1}}};
	localparam subPkg::operand_t minNeg = {1'b1, {(`SUB_WIDTH-1){1'b0}}};

	subPkg::operand_t aQ;
	subPkg::operand_t bQ;
	logic             borrowQ;
	logic             satQ;
	subPkg::operand_t rawDiff; // wrapped difference
	logic             rawOvf;

	always_ff @(posedge clk) begin
		if (rst) begin
			entryValid <= 1'b0;
		end else begin
			entryValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin // hold last operands otherwise
			aQ      <= inA;
			bQ      <= inB;
			borrowQ <= inBorrow;
			satQ    <= inSat;
		end
	end

	SubV #(.width(`SUB_WIDTH), .speed(`SUB_SPEED)) sub (
		.A(aQ), .B(bQ), .CI(borrowQ), .S(rawDiff), .V(rawOvf)
	);

	// on overflow the sign of A says which rail the true result passed
	always_comb begin
		entryResult = rawDiff;
		if (rawOvf && satQ) begin
			entryResult = aQ[`SUB_WIDTH-1] ? minNeg : maxPos;
		end
	end

	assign entryOverflow = rawOvf;

endmodule

// ==== design/resultQueue.sv ====
`include "sub_defines.svh"

module resultQueue (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  subPkg::operand_t pushResult,
	input  logic             pushOverflow,
	input  logic             pop,
	output logic             notEmpty,
	output subPkg::operand_t headResult,   // oldest entry
	output logic             headOverflow
);

	localparam int depth = `SUB_QDEPTH;
	localparam int cntW = $clog2(depth + 1);
	localparam subPkg::qPtr_t lastSlot = subPkg::qPtr_t'(depth - 1);
	localparam logic [cntW-1:0] fullCount = cntW'(depth);

	subPkg::operand_t resultMem [depth];
	logic             ovfMem [depth];
	subPkg::qPtr_t    wrPtr;
	subPkg::qPtr_t    rdPtr;
	logic [cntW-1:0]  count; // entries held

	always_ff @(posedge clk) begin
		if (push) begin
			resultMem[wrPtr] <= pushResult;
			ovfMem[wrPtr]    <= pushOverflow;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1; // wrap
			end
			if (pop) begin
				rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or push with pop
			endcase
		end
	end

	assign notEmpty     = (count != '0);
	assign headResult   = resultMem[rdPtr];
	assign headOverflow = ovfMem[rdPtr];

	// upstream credits must keep the in-flight count within depth
	noPushFull: assert property (@(posedge clk) disable iff (rst) push |-> count != fullCount)
		else $error("result queue: push while full");
	noPopEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty)
		else $error("result queue: pop while empty");

endmodule

// ==== design/subCtrl.sv ====
`include "sub_defines.svh"

module subCtrl (
	input  logic             clk,
	input  logic             rst,
	input  logic             notEmpty,
	input  subPkg::operand_t headResult,
	input  logic             headOverflow,
	input  logic             outCredit,   // credit pulse from downstream
	output logic             pop,
	output logic             outValid,
	output subPkg::operand_t outResult,
	output logic             outOverflow,
	output logic             inCredit     // credit pulse to upstream
);

	localparam subPkg::credit_t maxCredits = subPkg::credit_t'(`SUB_OUT_CREDITS);

	subPkg::credit_t creditCnt; // downstream credits on hand

	// send only when something waits and the receiver has room
	assign pop = notEmpty && (creditCnt != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			creditCnt <= maxCredits;
			outValid  <= 1'b0;
			inCredit  <= 1'b0;
		end else begin
			outValid <= pop;
			inCredit <= pop; // freed queue slot goes back upstream
			case ({pop, outCredit})
				2'b10:   creditCnt <= creditCnt - 1'b1; // spent
				2'b01:   creditCnt <= creditCnt + 1'b1; // returned
				default: creditCnt <= creditCnt;        // neither, or both cancel
			endcase
		end
	end

	// output payload register
	always_ff @(posedge clk) begin
		if (pop) begin
			outResult   <= headResult;
			outOverflow <= headOverflow;
		end
	end

	// downstream must not return more credits than it was given
	creditBound: assert property (@(posedge clk) disable iff (rst) creditCnt <= maxCredits)
		else $error("credit counter above reset value");

endmodule

// ==== design/subUnitTop.sv ====
module subUnitTop (
	input  logic             clk,
	input  logic             rst,
	input  logic             inValid,
	input  subPkg::operand_t inA,
	input  subPkg::operand_t inB,
	input  logic             inBorrow,
	input  logic             inSat,
	input  logic             outCredit,
	output logic             inCredit,
	output logic             outValid,
	output subPkg::operand_t outResult,
	output logic             outOverflow
);

	// stage to queue
	logic             entryValid;
	subPkg::operand_t entryResult;
	logic             entryOverflow;

	// queue to control
	logic             notEmpty;
	subPkg::operand_t headResult;
	logic             headOverflow;
	logic             pop;

	diffStage stage (
		.clk(clk), .rst(rst),
		.inValid(inValid), .inA(inA), .inB(inB), .inBorrow(inBorrow), .inSat(inSat),
		.entryValid(entryValid), .entryResult(entryResult), .entryOverflow(entryOverflow)
	);

	resultQueue queue (
		.clk(clk), .rst(rst),
		.push(entryValid), .pushResult(entryResult), .pushOverflow(entryOverflow),
		.pop(pop),
		.notEmpty(notEmpty), .headResult(headResult), .headOverflow(headOverflow)
	);

	subCtrl ctrl (
		.clk(clk), .rst(rst),
		.notEmpty(notEmpty), .headResult(headResult), .headOverflow(headOverflow),
		.outCredit(outCredit), .pop(pop),
		.outValid(outValid), .outResult(outResult), .outOverflow(outOverflow),
		.inCredit(inCredit)
	);

endmodule

// ==== dv/subUnitTb.sv ====
`include "sub_defines.svh"

module subUnitTb;

	localparam int clkPeriod = 40;
	localparam int numTx = 36;     // data lines in the golden file
	localparam int holdWait = 20;  // cycles to watch a stalled output

	logic             clk;
	logic             rst;
	logic             inValid;
	subPkg::operand_t inA;
	subPkg::operand_t inB;
	logic             inBorrow;
	logic             inSat;
	logic             outCredit;
	logic             inCredit;
	logic             outValid;
	subPkg::operand_t outResult;
	logic             outOverflow;

	// six words per transaction in a b borrow sat result overflow order
	logic [`SUB_WIDTH-1:0] goldenMem [0:numTx*6-1];

	int expIdx = 0;         // next golden entry expected at the output
	int received = 0;       // results seen on outValid
	int sentCount = 0;      // transactions driven upstream
	int upReturned = 0;     // inCredit pulses seen
	int dnReturned = 0;     // outCredit pulses given
	int checks = 0;
	int errors = 0;
	logic holdCredits = 1'b0; // stalls the credit returner

	subUnitTop dut (
		.clk(clk), .rst(rst),
		.inValid(inValid), .inA(inA), .inB(inB), .inBorrow(inBorrow), .inSat(inSat),
		.outCredit(outCredit), .inCredit(inCredit),
		.outValid(outValid), .outResult(outResult), .outOverflow(outOverflow)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// watchdog with a generous per-transaction budget
	initial begin
		#(numTx * 40 * clkPeriod);
		$display("timeout: the run did not finish within %0d time units",
			numTx * 40 * clkPeriod);
		$display("TEST FAILED");
		$finish;
	end

	// compare one output beat with the next golden line
	task automatic checkOutput();
		subPkg::operand_t expRes;
		logic             expOvf;
		checks++;
		assert (expIdx < numTx) else begin
			$display("an extra result came out at time %0t after all golden lines", $time);
			errors++;
		end
		if (expIdx < numTx) begin
			expRes = goldenMem[6*expIdx+4];
			expOvf = goldenMem[6*expIdx+5][0];
			checks += 2;
			assert (outResult === expRes) else begin
				$display("Fail at %0t: tx %0d result %h, expected %h",
					$time, expIdx, outResult, expRes);
				errors++;
			end
			assert (outOverflow === expOvf) else begin
				$display("Fail at %0t: tx %0d overflow %b, expected %b",
					$time, expIdx, outOverflow, expOvf);
				errors++;
			end
			expIdx++;
		end
		received++;
	endtask

	// monitor sees the cycle that just ended
	always @(posedge clk) begin
		if (!rst) begin
			if (inCredit) begin
				checks++;
				assert (upReturned < sentCount) else begin
					$display("a credit came back upstream at time %0t with nothing outstanding",
						$time);
					errors++;
				end
				upReturned++; // slot freed upstream
			end
			if (outValid) begin
				checkOutput();
			end
		end
	end

	// downstream receiver hands credits back after random delays
	always @(negedge clk) begin
		if (!rst && !holdCredits && (received > dnReturned) && ($urandom % 3 == 0)) begin
			outCredit = 1'b1;
			dnReturned++;
		end else begin
			outCredit = 1'b0;
		end
	end

	// upstream sender spends one credit per transaction
	task automatic driveRange(input int first, input int count);
		int gap;
		@(negedge clk);
		for (int t = first; t < first + count; t++) begin
			gap = $urandom % 3;
			inValid = 1'b0;
			repeat (gap) @(negedge clk);
			while (sentCount - upReturned >= `SUB_QDEPTH) @(negedge clk); // out of credits
			inA      = goldenMem[6*t];
			inB      = goldenMem[6*t+1];
			inBorrow = goldenMem[6*t+2][0];
			inSat    = goldenMem[6*t+3][0];
			inValid  = 1'b1;
			sentCount++;
			@(negedge clk);
		end
		inValid = 1'b0;
	endtask

	task automatic waitResults(input int target);
		while (received < target) @(negedge clk);
	endtask

	task automatic runGroup(input string name, input int first, input int count);
		int errBase;
		errBase = errors;
		driveRange(first, count);
		waitResults(first + count);
		$display("%s: %0d results, %0d errors", name, count, errors - errBase);
	endtask

	initial begin
		int errBase;
		int phaseBase;
		clk       = 1'b0;
		rst       = 1'b1;
		inValid   = 1'b0;
		inA       = '0;
		inB       = '0;
		inBorrow  = 1'b0;
		inSat     = 1'b0;
		outCredit = 1'b0;
		void'($urandom(32'h0a904dc6));
		$readmemh("dv/sub_golden.txt", goldenMem);
		repeat (8) @(negedge clk);
		rst = 1'b0;

		runGroup("plain difference", 0, 10);
		runGroup("borrow in", 10, 8);
		runGroup("overflow and clamp", 18, 12);

		// back-pressure starts with every downstream credit home, then withholds them
		errBase = errors;
		while (dnReturned != received) @(posedge clk);
		holdCredits = 1'b1;
		phaseBase = received;
		driveRange(30, 6);
		repeat (holdWait) @(negedge clk);
		checks++;
		assert (received - phaseBase == `SUB_OUT_CREDITS) else begin
			$display("Fail at %0t: %0d results while credits held, expected %0d",
				$time, received - phaseBase, `SUB_OUT_CREDITS);
			errors++;
		end
		@(posedge clk);
		holdCredits = 1'b0;
		waitResults(36);
		$display("credit back-pressure: 6 results, %0d errors", errors - errBase);

		// every pop returned exactly one upstream credit
		errBase = errors;
		checks += 2;
		assert (upReturned == received) else begin
			$display("Fail at %0t: %0d upstream credits for %0d results",
				$time, upReturned, received);
			errors++;
		end
		assert (received == numTx) else begin
			$display("Fail at %0t: %0d results, expected %0d", $time, received, numTx);
			errors++;
		end
		$display("credit conservation: %0d errors", errors - errBase);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== subUnitTop.f ====
+incdir+design
design/subPkg.sv
design/PrefixAndOr.sv
design/SubV.sv
design/diffStage.sv
design/resultQueue.sv
design/subCtrl.sv
design/subUnitTop.sv
dv/subUnitTb.sv

// ==== Bender.yml ====
package:
  name: sub_unit

sources:
  - include_dirs:
      - design
    files:
      - design/subPkg.sv
      - design/PrefixAndOr.sv
      - design/SubV.sv
      - design/diffStage.sv
      - design/resultQueue.sv
      - design/subCtrl.sv
      - design/subUnitTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/subUnitTb.sv

// ==== dv/sub_golden.txt ====
// columns: a b borrow saturate result overflow, all hex
// lines 0-9 plain, 10-17 borrow, 18-29 overflow, 30-35 back-pressure
0005 0003 0 0 0002 0
0003 0005 0 0 FFFE 0
1234 0234 0 0 1000 0
0000 0000 0 0 0000 0
FFFF 0001 0 0 FFFE 0
8000 FFFF 0 0 8001 0
7FFF 7FFF 0 0 0000 0
3000 D000 0 0 6000 0
ABCD 1234 0 0 9999 0
0100 FF00 0 0 0200 0
0005 0003 1 0 0001 0
0001 0000 1 0 0000 0
0000 0000 1 0 FFFF 0
0001 0001 1 0 FFFF 0
0000 0001 1 0 FFFE 0
1000 0FFF 1 0 0000 0
8001 0000 1 0 8000 0
FFFF FFFF 1 0 FFFF 0
7FFF FFFF 0 0 8000 1
7FFF FFFF 0 1 7FFF 1
8000 0001 0 0 7FFF 1
8000 0001 0 1 8000 1
8000 0000 1 0 7FFF 1
8000 0000 1 1 8000 1
4000 C000 0 0 8000 1
4000 C000 0 1 7FFF 1
C000 4001 0 0 7FFF 1
C000 4001 0 1 8000 1
0000 8000 0 0 8000 1
0000 8000 0 1 7FFF 1
0010 0001 0 0 000F 0
0020 0002 0 1 001E 0
8000 7FFF 0 1 8000 1
7FFE FFFE 1 0 7FFF 0
1234 4321 0 0 CF13 0
0001 0002 1 1 FFFE 0
